// File: video_pkg.sv
// video colour output stage shared types and PWM dither table
`default_nettype none

package video_pkg;

	// palette RAM size, one entry per 8-bit index
	localparam int PAL_DEPTH = 256;

	// pixel byte from a raster source
	typedef logic [7:0] plex_t;

	// palette RAM address
	typedef logic [7:0] pal_idx_t;

	// palette entry: dac mode flag on top, then 5 bits of red, green, blue
	typedef logic [15:0] pal_word_t;

	// raw colour without the mode flag
	typedef logic [14:0] rgb15_t;

	// one dithered channel for the 2-bit resistor DAC
	typedef logic [1:0] dac2_t;

	// both sub-phase values of every channel, serialized by the DDR cell
	typedef struct packed {
		dac2_t red1;
		dac2_t grn1;
		dac2_t blu1;
		dac2_t red0;
		dac2_t grn0;
		dac2_t blu0;
	} dac_pair_t;

	// ordered PWM patterns indexed by the 3-bit fine intensity
	// bit position is phase * 2 + sub-phase
	localparam logic [7:0] pwm_pattern [0:7] = '{
		8'b00000000,
		8'b00000001,
		8'b01000001,
		8'b01000101,
		8'b10100101,
		8'b10100111,
		8'b11010111,
		8'b11011111
	};

endpackage

`default_nettype wire

// File: video_cram.sv
// palette colour RAM with a CPU write port and a registered video read port
`default_nettype none

module video_cram (
	input  wire                  clk,
	input  video_pkg::pal_idx_t  wr_addr,
	input  video_pkg::pal_word_t wr_data,
	input  wire                  wr_en,
	input  video_pkg::pal_idx_t  rd_addr,
	output video_pkg::pal_word_t rd_data
);

	import video_pkg::*;

	// contents are loaded by the CPU before display
	pal_word_t mem [PAL_DEPTH];

	// CPU side write
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	// video side read, one cycle latency
	// a same-cycle write to this address is seen on the next read only
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: video_pixel_select.sv
// pixel selector forming the palette index and blank level from TV or VGA raster
`default_nettype none

module video_pixel_select (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 vga_on,
	input  wire                 tv_strobe,
	input  wire                 tv_hires,
	input  wire                 vga_hires,
	input  wire                 tv_blank,
	input  wire                 vga_blank,
	input  wire [1:0]           plex_sel,
	input  wire [3:0]           palsel,
	input  video_pkg::plex_t    tv_plex,
	input  video_pkg::plex_t    vga_plex,
	output video_pkg::pal_idx_t pal_idx,
	output logic                blank
);

	import video_pkg::*;

	plex_t tv_byte;
	plex_t plex;
	logic  hires;
	logic  nib_low;
	logic [3:0] nibble;

	// TV raster runs slower than clk, so hold its byte between strobes
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tv_byte <= '0;
		end
		else if (tv_strobe)
		begin
			tv_byte <= tv_plex;
		end
	end

	// source and mode follow vga_on
	always_comb
	begin
		if (vga_on)
		begin
			plex    = vga_plex;
			hires   = vga_hires;
			nib_low = plex_sel[0];
			blank   = vga_blank;
		end
		else
		begin
			plex    = tv_byte;
			hires   = tv_hires;
			nib_low = plex_sel[1];
			blank   = tv_blank;
		end
	end

	// nibble choice for hires, low nibble when the select bit is set
	assign nibble = nib_low ? plex[3:0] : plex[7:4];

	// hires uses palsel as the bank, lores takes the whole byte
	always_comb
	begin
		if (hires)
		begin
			pal_idx = {palsel, nibble};
		end
		else
		begin
			pal_idx = plex;
		end
	end

endmodule

`default_nettype wire

// File: video_pwm_dither.sv
// ordered PWM dither reducing 5-bit palette channels to 2-bit DAC values
`default_nettype none

module video_pwm_dither (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  vga_on,
	input  wire                  vga_line,
	input  wire                  blank,
	input  video_pkg::pal_word_t pixel,
	output video_pkg::dac_pair_t dac,
	output video_pkg::rgb15_t    raw,
	output logic                 dac_mode
);

	import video_pkg::*;

	logic       blank_d;
	pal_word_t  pix;
	logic [4:0] red;
	logic [4:0] grn;
	logic [4:0] blu;
	logic [1:0] ph_cnt;
	logic [1:0] phase;
	logic [2:0] pos0;
	logic [2:0] pos1;

	// coarse part plus one where the pattern bit is set, saturating at 3
	function automatic dac2_t dither_chan(input logic [4:0] chan, input logic [2:0] pos);
		dac2_t      coarse;
		logic [2:0] fine;
		logic [7:0] pattern;
		coarse  = chan[4:3];
		fine    = chan[2:0];
		pattern = pwm_pattern[fine];
		if (pattern[pos] && coarse != 2'd3)
		begin
			dither_chan = coarse + 2'd1;
		end
		else
		begin
			dither_chan = coarse;
		end
	endfunction

	// blank arrives with the index, palette word a cycle later
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			blank_d <= 1'b0;
		end
		else
		begin
			blank_d <= blank;
		end
	end

	assign pix = blank_d ? '0 : pixel;

	// channel split
	assign red = pix[14:10];
	assign grn = pix[9:5];
	assign blu = pix[4:0];

	// free-running phase
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ph_cnt <= 2'd0;
		end
		else
		begin
			ph_cnt <= ph_cnt + 2'd1;
		end
	end

	// VGA doubles lines, so the scan line picks the upper phase bit
	assign phase = {vga_on ? vga_line : ph_cnt[1], ph_cnt[0]};
	assign pos0  = {phase, 1'b0};
	assign pos1  = {phase, 1'b1};

	// both sub-phases, raw colour and mode flag share one register stage
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dac      <= '0;
			raw      <= '0;
			dac_mode <= 1'b0;
		end
		else
		begin
			dac.red0 <= dither_chan(red, pos0);
			dac.grn0 <= dither_chan(grn, pos0);
			dac.blu0 <= dither_chan(blu, pos0);
			dac.red1 <= dither_chan(red, pos1);
			dac.grn1 <= dither_chan(grn, pos1);
			dac.blu1 <= dither_chan(blu, pos1);
			raw      <= pix[14:0];
			dac_mode <= pix[15];
		end
	end

endmodule

`default_nettype wire

// File: video_out.sv
// video colour output stage from raster byte to dithered DAC values
`default_nettype none

module video_out (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  vga_on,
	input  wire                  vga_line,
	input  wire                  tv_strobe,
	input  wire                  tv_hires,
	input  wire                  vga_hires,
	input  wire                  tv_blank,
	input  wire                  vga_blank,
	input  wire [1:0]            plex_sel,
	input  wire [3:0]            palsel,
	input  video_pkg::plex_t     tv_plex,
	input  video_pkg::plex_t     vga_plex,
	input  video_pkg::pal_idx_t  cram_addr,
	input  video_pkg::pal_word_t cram_data,
	input  wire                  cram_we,
	output video_pkg::dac_pair_t dac,
	output video_pkg::rgb15_t    raw,
	output logic                 dac_mode
);

	import video_pkg::*;

	pal_idx_t  pal_idx;
	logic      blank;
	pal_word_t pal_word;

	// index and blank, combinational from the raster inputs
	video_pixel_select u_select (
		.clk       (clk),
		.arst_n    (arst_n),
		.vga_on    (vga_on),
		.tv_strobe (tv_strobe),
		.tv_hires  (tv_hires),
		.vga_hires (vga_hires),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.plex_sel  (plex_sel),
		.palsel    (palsel),
		.tv_plex   (tv_plex),
		.vga_plex  (vga_plex),
		.pal_idx   (pal_idx),
		.blank     (blank)
	);

	// palette lookup, first pipeline stage
	video_cram u_cram (
		.clk     (clk),
		.wr_addr (cram_addr),
		.wr_data (cram_data),
		.wr_en   (cram_we),
		.rd_addr (pal_idx),
		.rd_data (pal_word)
	);

	// dither and output registers, second pipeline stage
	video_pwm_dither u_dither (
		.clk      (clk),
		.arst_n   (arst_n),
		.vga_on   (vga_on),
		.vga_line (vga_line),
		.blank    (blank),
		.pixel    (pal_word),
		.dac      (dac),
		.raw      (raw),
		.dac_mode (dac_mode)
	);

endmodule

`default_nettype wire

// File: video_out_monitor.sv
// output monitor modelling the palette pipeline and PWM dither rule for comparison
`default_nettype none

module video_out_monitor (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  vga_on,
	input  wire                  vga_line,
	input  wire                  pix_valid,
	input  wire                  pix_blank,
	input  video_pkg::pal_word_t exp_word,
	input  video_pkg::dac_pair_t dac,
	input  video_pkg::rgb15_t    raw,
	input  wire                  dac_mode,
	output int                   errors
);

	import video_pkg::*;

	// ordered dither patterns, one per fine intensity
	localparam logic [7:0] ref_pattern [0:7] = '{
		8'h00, 8'h01, 8'h41, 8'h45, 8'hA5, 8'hA7, 8'hD7, 8'hDF
	};

	logic      s1_valid;
	pal_word_t s1_word;
	logic      s2_valid;
	dac_pair_t s2_dac;
	rgb15_t    s2_raw;
	logic      s2_mode;
	logic [1:0] cnt;
	logic [1:0] phase;

	function automatic dac2_t level(input logic [4:0] chan, input logic [2:0] pos);
		logic [7:0] pat;
		pat = ref_pattern[chan[2:0]];
		if (pat[pos] && chan[4:3] != 2'd3)
			level = chan[4:3] + 2'd1;
		else
			level = chan[4:3];
	endfunction

	function automatic dac_pair_t expect_dac(input pal_word_t w, input logic [1:0] ph);
		dac_pair_t d;
		d.red0 = level(w[14:10], {ph, 1'b0});
		d.grn0 = level(w[9:5], {ph, 1'b0});
		d.blu0 = level(w[4:0], {ph, 1'b0});
		d.red1 = level(w[14:10], {ph, 1'b1});
		d.grn1 = level(w[9:5], {ph, 1'b1});
		d.blu1 = level(w[4:0], {ph, 1'b1});
		expect_dac = d;
	endfunction

	// VGA line replaces the upper phase bit
	assign phase = {vga_on ? vga_line : cnt[1], cnt[0]};

	always @(posedge clk or negedge arst_n)
	begin : compare
		int n;
		n = 0;
		if (!arst_n)
		begin
			s1_valid <= 1'b0;
			s1_word  <= '0;
			s2_valid <= 1'b0;
			s2_dac   <= '0;
			s2_raw   <= '0;
			s2_mode  <= 1'b0;
			cnt      <= 2'd0;
			errors   <= 0;
		end
		else
		begin
			if (s2_valid)
			begin
				if (dac !== s2_dac)
				begin
					$display("[ERROR] dac: got %h expected %h", dac, s2_dac);
					n = n + 1;
				end
				if (raw !== s2_raw)
				begin
					$display("[ERROR] raw: got %h expected %h", raw, s2_raw);
					n = n + 1;
				end
				if (dac_mode !== s2_mode)
				begin
					$display("[ERROR] dac_mode: got %h expected %h", dac_mode, s2_mode);
					n = n + 1;
				end
			end
			errors   <= errors + n;
			s2_valid <= s1_valid;
			s2_dac   <= expect_dac(s1_word, phase);
			s2_raw   <= s1_word[14:0];
			s2_mode  <= s1_word[15];
			s1_valid <= pix_valid;
			s1_word  <= pix_blank ? '0 : exp_word;
			cnt      <= cnt + 2'd1;
		end
	end

endmodule

`default_nettype wire

// File: video_out_checker.sv
// bound assertions on reset and blanking of the video output stage
`default_nettype none

module video_out_checker (
	input wire                  clk,
	input wire                  arst_n,
	input wire                  vga_on,
	input wire                  tv_blank,
	input wire                  vga_blank,
	input video_pkg::dac_pair_t dac,
	input video_pkg::rgb15_t    raw,
	input wire                  dac_mode
);

	timeunit 1ns;
	timeprecision 1ps;

	logic sel_blank;
	int   fails = 0;

	assign sel_blank = vga_on ? vga_blank : tv_blank;

	// each edge with reset low leaves zero outputs behind it
	reset_zero: assert property (@(posedge clk)
		!arst_n |=> (dac == '0 && raw == '0 && !dac_mode))
		else
		begin
			$error("outputs not zero during or right after reset");
			fails++;
		end

	// blank reaches the outputs two edges later
	blank_zero: assert property (@(posedge clk) disable iff (!arst_n)
		sel_blank |-> ##2 (dac == '0 && raw == '0 && !dac_mode))
		else
		begin
			$error("blanked pixel did not give zero outputs");
			fails++;
		end

endmodule

bind video_out video_out_checker u_checker (
	.clk       (clk),
	.arst_n    (arst_n),
	.vga_on    (vga_on),
	.tv_blank  (tv_blank),
	.vga_blank (vga_blank),
	.dac       (dac),
	.raw       (raw),
	.dac_mode  (dac_mode)
);

`default_nettype wire

// File: tb_video_out.sv
// testbench for the video colour output stage driven from a pattern file
`default_nettype none

module tb_video_out;

	timeunit 1ns;
	timeprecision 1ps;

	import video_pkg::*;

	localparam int MAX_LINES = 64;

	logic        clk;
	logic        arst_n;
	logic        vga_on;
	logic        vga_line;
	logic        tv_strobe;
	logic        tv_hires;
	logic        vga_hires;
	logic        tv_blank;
	logic        vga_blank;
	logic [1:0]  plex_sel;
	logic [3:0]  palsel;
	plex_t       tv_plex;
	plex_t       vga_plex;
	pal_idx_t    cram_addr;
	pal_word_t   cram_data;
	logic        cram_we;
	dac_pair_t   dac;
	rgb15_t      raw;
	logic        dac_mode;
	logic        pix_valid;
	logic        pix_blank;
	pal_word_t   exp_word;
	logic [63:0] patterns [MAX_LINES];
	int          n_lines;
	int          errors;
	int          setup_errors;
	int          assert_fails;
	logic        loaded;

	video_out dut (.*);

	video_out_monitor u_monitor (
		.clk       (clk),
		.arst_n    (arst_n),
		.vga_on    (vga_on),
		.vga_line  (vga_line),
		.pix_valid (pix_valid),
		.pix_blank (pix_blank),
		.exp_word  (exp_word),
		.dac       (dac),
		.raw       (raw),
		.dac_mode  (dac_mode),
		.errors    (errors)
	);

	always #5 clk = ~clk;

	// pattern line fields from the top nibble down
	// kind, control byte, plex_sel, palsel, tv byte or address, vga byte, padding, word
	task automatic apply_line(input logic [63:0] line);
		logic [3:0] kind;
		logic [7:0] ctrl;
		kind = line[63:60];
		ctrl = line[59:52];
		if (kind > 4'd2)
		begin
			$display("pattern line has an unknown kind %0d", kind);
			setup_errors = setup_errors + 1;
		end
		cram_we   <= (kind == 4'd1);
		cram_addr <= line[43:36];
		cram_data <= line[15:0];
		pix_valid <= (kind == 4'd2);
		vga_on    <= ctrl[0];
		vga_line  <= ctrl[1];
		tv_strobe <= ctrl[2];
		tv_hires  <= ctrl[3];
		vga_hires <= ctrl[4];
		tv_blank  <= ctrl[5];
		vga_blank <= ctrl[6];
		pix_blank <= ctrl[0] ? ctrl[6] : ctrl[5];
		plex_sel  <= line[49:48];
		palsel    <= line[47:44];
		tv_plex   <= line[43:36];
		vga_plex  <= line[35:28];
		exp_word  <= line[15:0];
	endtask

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		loaded = 1'b0;
		setup_errors = 0;
		assert_fails = 0;
		n_lines = 0;
		apply_line('0);
		$readmemh("video_patterns.txt", patterns);
		while (n_lines < MAX_LINES && !$isunknown(patterns[n_lines])
			&& patterns[n_lines][63:60] != 4'hf)
			n_lines = n_lines + 1;
		if (n_lines == 0)
		begin
			$display("no pattern lines could be read");
			setup_errors = setup_errors + 1;
		end
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < n_lines; i++)
		begin
			@(posedge clk);
			apply_line(patterns[i]);
		end
		@(posedge clk);
		apply_line('0);
		// drain the two-stage pipeline
		repeat (4) @(posedge clk);
		assert_fails = dut.u_checker.fails;
		$display("errors: %0d compare, %0d setup, %0d assertion",
			errors, setup_errors, assert_fails);
		if (errors == 0 && setup_errors == 0 && assert_fails == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		wait (loaded);
		repeat (n_lines + 8 + 50) @(posedge clk);
		$display("timeout: the pattern run did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: video_patterns.txt
// kind(1=write 2=pixel f=end)_ctrl_plexsel_palsel_tvbyte/addr_vgabyte_pad_word
// ctrl bits: 0 vga_on 1 vga_line 2 tv_strobe 3 tv_hires 4 vga_hires 5 tv_blank 6 vga_blank
1_00_0_0_00_00_000_0000
1_00_0_0_12_00_000_7FFF
1_00_0_0_34_00_000_8421
1_00_0_0_56_00_000_0C63
1_00_0_0_78_00_000_294A
1_00_0_0_9A_00_000_5AD6
1_00_0_0_35_00_000_1CE7
1_00_0_0_3C_00_000_14A5
1_00_0_0_4A_00_000_4210
1_00_0_0_4B_00_000_A529
2_01_0_0_00_12_000_7FFF
2_01_0_0_00_34_000_8421
2_03_0_0_00_56_000_0C63
2_03_0_0_00_78_000_294A
2_01_0_0_00_9A_000_5AD6
2_03_0_0_00_35_000_1CE7
2_04_0_0_34_00_000_0000
2_00_0_0_99_00_000_8421
2_00_0_0_77_00_000_8421
2_04_0_0_56_00_000_8421
2_00_0_0_00_00_000_0C63
2_04_0_0_AB_00_000_0C63
2_08_2_4_00_00_000_A529
2_08_0_4_00_00_000_4210
2_08_1_4_00_00_000_4210
2_11_1_3_00_5C_000_14A5
2_11_0_3_00_5C_000_1CE7
2_13_3_3_00_5C_000_14A5
2_13_2_3_00_5C_000_1CE7
2_20_0_0_00_00_000_0000
2_48_2_4_00_00_000_A529
2_41_0_0_00_12_000_0000
2_21_0_0_00_9A_000_5AD6
f_00_0_0_00_00_000_0000

// File: vlog.f
video_pkg.sv
video_cram.sv
video_pixel_select.sv
video_pwm_dither.sv
video_out.sv
video_out_monitor.sv
video_out_checker.sv
tb_video_out.sv

// File: Makefile
# Verilator build and run for the video colour output stage

VERILATOR ?= verilator
TOP       ?= tb_video_out
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
